//--- sources.f
+incdir+verif
source/core_pkg.sv
source/issue_queue.sv
source/buffer_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/issue_core.sv
verif/issue_core_tb.sv

//--- Bender.yml
package:
  name: issue_core

sources:
  - source/core_pkg.sv
  - source/issue_queue.sv
  - source/buffer_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/result_stage.sv
  - source/issue_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/issue_core_tb.sv

//--- verif/issue_core_program.svh
`ifndef issue_core_program_svh
`define issue_core_program_svh

// Columns: flush before fetch, hold result_ready low, instruction word
// Entry n is fetched at pc 4*n

localparam int prog_len = 30;

function automatic logic [33:0] program_entry(input int idx);
  case (idx)
    0:  program_entry = {1'b0, 1'b0, 32'h00500093};  // addi x1, x0, 5
    1:  program_entry = {1'b0, 1'b0, 32'hFFD00113};  // addi x2, x0, -3
    2:  program_entry = {1'b0, 1'b0, 32'h002081B3};  // add  x3, x1, x2
    3:  program_entry = {1'b0, 1'b0, 32'h40110233};  // sub  x4, x2, x1
    4:  program_entry = {1'b0, 1'b0, 32'h0041F2B3};  // and  x5, x3, x4
    5:  program_entry = {1'b0, 1'b0, 32'h0020E333};  // or   x6, x1, x2
    6:  program_entry = {1'b0, 1'b0, 32'h005343B3};  // xor  x7, x6, x5
    7:  program_entry = {1'b0, 1'b0, 32'h00112433};  // slt  x8, x2, x1
    8:  program_entry = {1'b0, 1'b0, 32'hFFF12493};  // slti x9, x2, -1
    9:  program_entry = {1'b0, 1'b0, 32'hFF80A513};  // slti x10, x1, -8
    10: program_entry = {1'b0, 1'b1, 32'h7F017593};  // andi x11, x2, 0x7f0
    11: program_entry = {1'b0, 1'b0, 32'hF000E613};  // ori  x12, x1, -256
    12: program_entry = {1'b0, 1'b0, 32'hFFF64693};  // xori x13, x12, -1
    13: program_entry = {1'b0, 1'b0, 32'h00900013};  // addi x0, x0, 9
    14: program_entry = {1'b0, 1'b0, 32'h00D00733};  // add  x14, x0, x13
    15: program_entry = {1'b0, 1'b0, 32'h0006A7B3};  // slt  x15, x13, x0
    16: program_entry = {1'b0, 1'b0, 32'h0020D833};  // srl, not supported
    17: program_entry = {1'b0, 1'b0, 32'h001808B3};  // add  x17, x16, x1
    18: program_entry = {1'b0, 1'b0, 32'h04D00093};  // addi x1, x0, 77
    19: program_entry = {1'b0, 1'b0, 32'h00110113};  // addi x2, x2, 1
    20: program_entry = {1'b1, 1'b0, 32'h002089B3};  // add  x19, x1, x2
    21: program_entry = {1'b0, 1'b0, 32'h40398A33};  // sub  x20, x19, x3
    22: program_entry = {1'b0, 1'b1, 32'h014A0AB3};  // add  x21, x20, x20
    23: program_entry = {1'b0, 1'b0, 32'h800A8B13};  // addi x22, x21, -2048
    24: program_entry = {1'b0, 1'b0, 32'h00DB4BB3};  // xor  x23, x22, x13
    25: program_entry = {1'b0, 1'b0, 32'h009BEC33};  // or   x24, x23, x9
    26: program_entry = {1'b0, 1'b0, 32'h005282B3};  // add  x5, x5, x5
    27: program_entry = {1'b0, 1'b0, 32'h001082B3};  // add  x5, x1, x1
    28: program_entry = {1'b0, 1'b0, 32'h00B2AC93};  // slti x25, x5, 11
    29: program_entry = {1'b0, 1'b0, 32'h018CFD33};  // and  x26, x25, x24
    default: program_entry = '0;
  endcase
endfunction

`endif

//--- verif/issue_core_tb.sv
`default_nettype none

module issue_core_tb import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  `include "issue_core_program.svh"

  localparam int hold_cycles  = 16;
  localparam int drain_cycles = 8;
  localparam int cycle_limit  = 4 * prog_len + 200;

  logic                 clock;
  logic                 reset;
  logic                 flush;
  logic                 fetch_valid;
  logic [xlen-1:0]      fetch_pc;
  instr_t               fetch_instr;
  logic                 fetch_ready;
  logic                 lane0_valid;
  logic [xlen-1:0]      lane0_pc;
  logic [reg_idx_w-1:0] lane0_rd;
  logic [xlen-1:0]      lane0_value;
  logic                 lane0_write;
  logic                 lane1_valid;
  logic [xlen-1:0]      lane1_pc;
  logic [reg_idx_w-1:0] lane1_rd;
  logic [xlen-1:0]      lane1_value;
  logic                 lane1_write;
  logic                 result_ready;

  logic [xlen-1:0] model_regs [reg_count];
  logic [xlen-1:0] pending_pc [$];     // Fetched, not yet retired
  logic [xlen-1:0] pending_instr [$];
  int              errors;
  int              retired;
  int              pair_transfers;
  int              full_cycles;
  integer          seed;

  issue_core uut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [xlen-1:0] actual,
                             input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, actual, expected);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model, RV32I semantics on the model register array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [xlen:0] model_result(input logic [31:0] word);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] value;
    logic            write;
    a     = model_regs[word[19:15]];
    b     = model_regs[word[24:20]];
    imm   = {{(xlen-12){word[31]}}, word[31:20]};
    value = '0;
    write = word[11:7] != 5'd0;  // x0 never written
    if (word[6:0] == 7'b0110011) begin
      case ({word[31:25], word[14:12]})
        10'b0000000_000: value = a + b;
        10'b0100000_000: value = a - b;
        10'b0000000_111: value = a & b;
        10'b0000000_110: value = a | b;
        10'b0000000_100: value = a ^ b;
        10'b0000000_010: value = ($signed(a) < $signed(b)) ? 1 : 0;
        default:         write = 1'b0;
      endcase
    end else if (word[6:0] == 7'b0010011) begin
      case (word[14:12])
        3'b000:  value = a + imm;
        3'b111:  value = a & imm;
        3'b110:  value = a | imm;
        3'b100:  value = a ^ imm;
        3'b010:  value = ($signed(a) < $signed(imm)) ? 1 : 0;
        default: write = 1'b0;
      endcase
    end else begin
      write = 1'b0;
    end
    return {write, value};
  endfunction

  // Younger reads a register that the older one writes
  function automatic logic pair_conflict(input logic [31:0] older, input logic [31:0] younger);
    logic [xlen:0] older_result;
    logic          reads1;
    logic          reads2;
    older_result = model_result(older);
    reads1 = younger[6:0] == 7'b0110011 || younger[6:0] == 7'b0010011;
    reads2 = younger[6:0] == 7'b0110011;
    return older_result[xlen] &&
           ((reads1 && younger[19:15] == older[11:7]) ||
            (reads2 && younger[24:20] == older[11:7]));
  endfunction

  task automatic retire_lane(input string lane, input logic [xlen-1:0] pc,
                             input logic [reg_idx_w-1:0] rd, input logic [xlen-1:0] value,
                             input logic write);
    logic [xlen-1:0] exp_pc;
    logic [31:0]     word;
    logic [xlen:0]   exp;
    if (pending_pc.size() == 0) begin
      $display("Result at pc %h on %s arrived with no instruction outstanding", pc, lane);
      errors++;
    end else begin
      exp_pc = pending_pc.pop_front();
      word   = pending_instr.pop_front();
      exp    = model_result(word);
      retired++;
      check_value({lane, "_pc"}, pc, exp_pc);
      check_value({lane, "_rd"}, rd, word[11:7]);
      check_value({lane, "_write"}, write, exp[xlen]);
      if (exp[xlen]) begin
        check_value({lane, "_value"}, value, exp[xlen-1:0]);
        model_regs[word[11:7]] = exp[xlen-1:0];
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus loop, sample at negedge and drive at posedge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int              cycle;
    int              idx;
    int              hold;
    int              gap;
    int              drain;
    logic            presenting;
    logic            flush_done;
    logic            finished;
    logic            stalled;
    logic            next_flush;
    logic            next_ready;
    logic [33:0]     entry;
    logic [xlen-1:0] snap_pc0;
    logic [xlen-1:0] snap_value0;
    logic            snap_valid1;
    logic [xlen-1:0] snap_value1;
    seed = 11796;
    errors = 0;
    retired = 0;
    pair_transfers = 0;
    full_cycles = 0;
    cycle = 0;
    idx = 0;
    hold = 0;
    gap = 0;
    drain = 0;
    presenting = 1'b0;
    flush_done = 1'b0;
    finished = 1'b0;
    stalled = 1'b0;
    entry = '0;
    reset = 1'b0;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_instr = '0;
    result_ready = 1'b1;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    repeat (8) @(posedge clock);
    reset <= 1'b1;

    while (!finished) begin
      @(negedge clock);
      cycle++;
      if (cycle > cycle_limit) begin
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        errors++;
        break;
      end
      if (cycle == 1) begin  // State right after reset
        check_value("lane0_valid", lane0_valid, 0);
        check_value("lane1_valid", lane1_valid, 0);
        check_value("fetch_ready", fetch_ready, 1);
      end

      if (stalled) begin  // Held through back-pressure
        check_value("lane0_valid", lane0_valid, 1);
        check_value("lane0_pc", lane0_pc, snap_pc0);
        check_value("lane0_value", lane0_value, snap_value0);
        check_value("lane1_valid", lane1_valid, snap_valid1);
        check_value("lane1_value", lane1_value, snap_value1);
      end
      stalled     = lane0_valid && !result_ready && !flush;
      snap_pc0    = lane0_pc;
      snap_value0 = lane0_value;
      snap_valid1 = lane1_valid;
      snap_value1 = lane1_value;

      if (lane1_valid && !lane0_valid) begin
        $display("Lane1 valid without lane0 at %0t", $time);
        errors++;
      end
      if (!flush && pending_pc.size() < queue_depth) begin
        check_value("fetch_ready", fetch_ready, 1);
      end
      if (!fetch_ready && !flush) full_cycles++;

      if (lane0_valid && result_ready) begin
        if (lane1_valid) begin
          pair_transfers++;
          if (pending_instr.size() >= 2 &&
              pair_conflict(pending_instr[0], pending_instr[1])) begin
            $display("Dependent instruction at pc %h issued beside its producer", lane1_pc);
            errors++;
          end
        end
        retire_lane("lane0", lane0_pc, lane0_rd, lane0_value, lane0_write);
        if (lane1_valid) begin
          retire_lane("lane1", lane1_pc, lane1_rd, lane1_value, lane1_write);
        end
      end
      if (flush) begin  // Committed above, the rest is gone
        pending_pc.delete();
        pending_instr.delete();
      end
      if (fetch_valid && fetch_ready) begin
        pending_pc.push_back(fetch_pc);
        pending_instr.push_back(fetch_instr);
        presenting = 1'b0;
        flush_done = 1'b0;
        idx++;
      end

      next_flush = 1'b0;
      if (!presenting && idx < prog_len) begin
        entry = program_entry(idx);
        if (entry[33] && !flush_done) begin
          // Leave the last two fetched in flight to be dropped
          if (pending_pc.size() <= 2) begin
            next_flush = 1'b1;
            flush_done = 1'b1;
          end
        end else begin
          presenting = 1'b1;
          if (entry[32]) hold = hold_cycles;
        end
      end

      if (hold > 0) begin
        next_ready = 1'b0;
        hold--;
      end else if (gap > 0) begin
        next_ready = 1'b0;
        gap--;
      end else if (($random(seed) & 7) == 0) begin
        next_ready = 1'b0;
        gap = $random(seed) & 3;
      end else begin
        next_ready = 1'b1;
      end

      if (idx == prog_len && !presenting && pending_pc.size() == 0) begin
        drain++;
        finished = drain >= drain_cycles;
      end

      @(posedge clock);
      flush        <= next_flush;
      result_ready <= next_ready;
      fetch_valid  <= presenting;
      fetch_pc     <= presenting ? idx * 4 : 0;
      fetch_instr  <= presenting ? entry[31:0] : 32'd0;
    end

    if (finished && pair_transfers == 0) begin
      $display("No independent pair ever retired together");
      errors++;
    end
    if (finished && full_cycles == 0) begin
      $display("Back-pressure never filled the queue");
      errors++;
    end
    $display("Summary: %0d errors, %0d instructions retired, %0d pair transfers",
             errors, retired, pair_transfers);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/issue_core.sv
`default_nettype none

module issue_core import core_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 fetch_valid,
  input  logic [xlen-1:0]      fetch_pc,
  input  instr_t               fetch_instr,
  output logic                 fetch_ready,
  output logic                 lane0_valid,
  output logic [xlen-1:0]      lane0_pc,
  output logic [reg_idx_w-1:0] lane0_rd,
  output logic [xlen-1:0]      lane0_value,
  output logic                 lane0_write,
  output logic                 lane1_valid,
  output logic [xlen-1:0]      lane1_pc,
  output logic [reg_idx_w-1:0] lane1_rd,
  output logic [xlen-1:0]      lane1_value,
  output logic                 lane1_write,
  input  logic                 result_ready
);

  logic stall;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage to stage wiring
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic                 iq_valid0, iq_valid1, buf_valid0, buf_valid1;
  logic [xlen-1:0]      iq_pc0, iq_pc1, buf_pc0, buf_pc1;
  instr_t               iq_instr0, iq_instr1, buf_instr0, buf_instr1;
  logic                 dec_valid0, dec_valid1, dec_uses_imm0, dec_uses_imm1;
  logic [xlen-1:0]      dec_pc0, dec_pc1, dec_imm0, dec_imm1;
  alu_op_t              dec_op0, dec_op1;
  logic [reg_idx_w-1:0] dec_rd0, dec_rd1, dec_rs1_0, dec_rs1_1, dec_rs2_0, dec_rs2_1;
  logic                 ex_valid0, ex_valid1, ex_write0, ex_write1;
  logic [xlen-1:0]      ex_pc0, ex_pc1, ex_value0, ex_value1;
  logic [reg_idx_w-1:0] ex_rd0, ex_rd1;
  logic                 held_valid0, held_valid1, held_write0, held_write1;
  logic [reg_idx_w-1:0] held_rd0, held_rd1, wb_rd0, wb_rd1;
  logic [xlen-1:0]      held_value0, held_value1, wb_value0, wb_value1;
  logic                 wb_enable0, wb_enable1;

  issue_queue u_issue_queue (
    .clock, .reset, .flush, .stall,
    .fetch_valid, .fetch_pc, .fetch_instr, .fetch_ready,
    .issue_valid0(iq_valid0), .issue_valid1(iq_valid1),
    .issue_pc0(iq_pc0), .issue_pc1(iq_pc1),
    .issue_instr0(iq_instr0), .issue_instr1(iq_instr1)
  );

  buffer_stage u_buffer_stage (
    .clock, .reset, .flush, .stall,
    .valid_in0(iq_valid0), .valid_in1(iq_valid1), .pc_in0(iq_pc0), .pc_in1(iq_pc1),
    .instr_in0(iq_instr0), .instr_in1(iq_instr1),
    .valid0(buf_valid0), .valid1(buf_valid1), .pc0(buf_pc0), .pc1(buf_pc1),
    .instr0(buf_instr0), .instr1(buf_instr1)
  );

  decode_stage u_decode_stage (
    .clock, .reset, .flush, .stall,
    .buf_valid0, .buf_valid1, .buf_pc0, .buf_pc1, .buf_instr0, .buf_instr1,
    .valid0(dec_valid0), .pc0(dec_pc0), .op0(dec_op0), .rd0(dec_rd0),
    .rs1_0(dec_rs1_0), .rs2_0(dec_rs2_0), .imm0(dec_imm0), .uses_imm0(dec_uses_imm0),
    .valid1(dec_valid1), .pc1(dec_pc1), .op1(dec_op1), .rd1(dec_rd1),
    .rs1_1(dec_rs1_1), .rs2_1(dec_rs2_1), .imm1(dec_imm1), .uses_imm1(dec_uses_imm1)
  );

  execute_stage u_execute_stage (
    .clock, .reset, .flush, .stall,
    .dec_valid0, .dec_pc0, .dec_op0, .dec_rd0, .dec_rs1_0, .dec_rs2_0,
    .dec_imm0, .dec_uses_imm0,
    .dec_valid1, .dec_pc1, .dec_op1, .dec_rd1, .dec_rs1_1, .dec_rs2_1,
    .dec_imm1, .dec_uses_imm1,
    .held_valid0, .held_rd0, .held_value0, .held_write0,
    .held_valid1, .held_rd1, .held_value1, .held_write1,
    .wb_enable0, .wb_rd0, .wb_value0, .wb_enable1, .wb_rd1, .wb_value1,
    .valid0(ex_valid0), .pc0(ex_pc0), .rd0(ex_rd0), .write0(ex_write0), .value0(ex_value0),
    .valid1(ex_valid1), .pc1(ex_pc1), .rd1(ex_rd1), .write1(ex_write1), .value1(ex_value1)
  );

  result_stage u_result_stage (
    .clock, .reset, .flush, .result_ready,
    .ex_valid0, .ex_pc0, .ex_rd0, .ex_write0, .ex_value0,
    .ex_valid1, .ex_pc1, .ex_rd1, .ex_write1, .ex_value1,
    .lane0_valid, .lane0_pc, .lane0_rd, .lane0_value, .lane0_write,
    .lane1_valid, .lane1_pc, .lane1_rd, .lane1_value, .lane1_write,
    .held_valid0, .held_rd0, .held_value0, .held_write0,
    .held_valid1, .held_rd1, .held_value1, .held_write1,
    .wb_enable0, .wb_rd0, .wb_value0, .wb_enable1, .wb_rd1, .wb_value1,
    .stall
  );

endmodule

`default_nettype wire

//--- source/result_stage.sv
`default_nettype none

module result_stage import core_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 result_ready,
  input  logic                 ex_valid0,
  input  logic [xlen-1:0]      ex_pc0,
  input  logic [reg_idx_w-1:0] ex_rd0,
  input  logic                 ex_write0,
  input  logic [xlen-1:0]      ex_value0,
  input  logic                 ex_valid1,
  input  logic [xlen-1:0]      ex_pc1,
  input  logic [reg_idx_w-1:0] ex_rd1,
  input  logic                 ex_write1,
  input  logic [xlen-1:0]      ex_value1,
  output logic                 lane0_valid,
  output logic [xlen-1:0]      lane0_pc,
  output logic [reg_idx_w-1:0] lane0_rd,
  output logic [xlen-1:0]      lane0_value,
  output logic                 lane0_write,
  output logic                 lane1_valid,
  output logic [xlen-1:0]      lane1_pc,
  output logic [reg_idx_w-1:0] lane1_rd,
  output logic [xlen-1:0]      lane1_value,
  output logic                 lane1_write,
  output logic                 held_valid0,
  output logic [reg_idx_w-1:0] held_rd0,
  output logic [xlen-1:0]      held_value0,
  output logic                 held_write0,
  output logic                 held_valid1,
  output logic [reg_idx_w-1:0] held_rd1,
  output logic [xlen-1:0]      held_value1,
  output logic                 held_write1,
  output logic                 wb_enable0,
  output logic [reg_idx_w-1:0] wb_rd0,
  output logic [xlen-1:0]      wb_value0,
  output logic                 wb_enable1,
  output logic [reg_idx_w-1:0] wb_rd1,
  output logic [xlen-1:0]      wb_value1,
  output logic                 stall
);

  logic transfer;

  assign stall    = lane0_valid && !result_ready;  // Freezes the whole core
  assign transfer = lane0_valid && result_ready;

  // A transfer commits even while flush is high
  assign wb_enable0 = transfer && lane0_write;
  assign wb_enable1 = transfer && lane1_valid && lane1_write;
  assign wb_rd0     = lane0_rd;
  assign wb_value0  = lane0_value;
  assign wb_rd1     = lane1_rd;
  assign wb_value1  = lane1_value;

  assign held_valid0 = lane0_valid;
  assign held_rd0    = lane0_rd;
  assign held_value0 = lane0_value;
  assign held_write0 = lane0_write;
  assign held_valid1 = lane1_valid;
  assign held_rd1    = lane1_rd;
  assign held_value1 = lane1_value;
  assign held_write1 = lane1_write;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      lane0_valid <= 1'b0;
      lane1_valid <= 1'b0;
    end else if (!stall) begin  // Empty or transferring
      lane0_valid <= ex_valid0;
      lane1_valid <= ex_valid1;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      lane0_pc    <= ex_pc0;
      lane0_rd    <= ex_rd0;
      lane0_value <= ex_value0;
      lane0_write <= ex_write0;
      lane1_pc    <= ex_pc1;
      lane1_rd    <= ex_rd1;
      lane1_value <= ex_value1;
      lane1_write <= ex_write1;
    end
  end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`default_nettype none

module execute_stage import core_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 stall,
  input  logic                 dec_valid0,
  input  logic [xlen-1:0]      dec_pc0,
  input  alu_op_t              dec_op0,
  input  logic [reg_idx_w-1:0] dec_rd0,
  input  logic [reg_idx_w-1:0] dec_rs1_0,
  input  logic [reg_idx_w-1:0] dec_rs2_0,
  input  logic [xlen-1:0]      dec_imm0,
  input  logic                 dec_uses_imm0,
  input  logic                 dec_valid1,
  input  logic [xlen-1:0]      dec_pc1,
  input  alu_op_t              dec_op1,
  input  logic [reg_idx_w-1:0] dec_rd1,
  input  logic [reg_idx_w-1:0] dec_rs1_1,
  input  logic [reg_idx_w-1:0] dec_rs2_1,
  input  logic [xlen-1:0]      dec_imm1,
  input  logic                 dec_uses_imm1,
  input  logic                 held_valid0,
  input  logic [reg_idx_w-1:0] held_rd0,
  input  logic [xlen-1:0]      held_value0,
  input  logic                 held_write0,
  input  logic                 held_valid1,
  input  logic [reg_idx_w-1:0] held_rd1,
  input  logic [xlen-1:0]      held_value1,
  input  logic                 held_write1,
  input  logic                 wb_enable0,
  input  logic [reg_idx_w-1:0] wb_rd0,
  input  logic [xlen-1:0]      wb_value0,
  input  logic                 wb_enable1,
  input  logic [reg_idx_w-1:0] wb_rd1,
  input  logic [xlen-1:0]      wb_value1,
  output logic                 valid0,
  output logic [xlen-1:0]      pc0,
  output logic [reg_idx_w-1:0] rd0,
  output logic                 write0,
  output logic [xlen-1:0]      value0,
  output logic                 valid1,
  output logic [xlen-1:0]      pc1,
  output logic [reg_idx_w-1:0] rd1,
  output logic                 write1,
  output logic [xlen-1:0]      value1
);

  logic [xlen-1:0] regs [reg_count];
  logic [xlen-1:0] a0, b0, a1, b1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand read with the youngest producer first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [xlen-1:0] operand(input logic [reg_idx_w-1:0] idx);
    if (idx == '0) operand = '0;
    else if (valid1 && write1 && rd1 == idx) operand = value1;  // Own register
    else if (valid0 && write0 && rd0 == idx) operand = value0;
    else if (held_valid1 && held_write1 && held_rd1 == idx) operand = held_value1;
    else if (held_valid0 && held_write0 && held_rd0 == idx) operand = held_value0;
    else operand = regs[idx];
  endfunction

  function automatic logic [xlen-1:0] alu(input alu_op_t op, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
    case (op)
      op_add, op_addi: alu = a + b;
      op_sub:          alu = a - b;
      op_and, op_andi: alu = a & b;
      op_or, op_ori:   alu = a | b;
      op_xor, op_xori: alu = a ^ b;
      op_slt, op_slti: alu = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      default:         alu = '0;
    endcase
  endfunction

  always_comb begin
    a0 = operand(dec_rs1_0);
    b0 = dec_uses_imm0 ? dec_imm0 : operand(dec_rs2_0);
    a1 = operand(dec_rs1_1);
    b1 = dec_uses_imm1 ? dec_imm1 : operand(dec_rs2_1);
  end

  // Lane1 writes last so it wins on equal rd
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb_enable0 && wb_rd0 != '0) regs[wb_rd0] <= wb_value0;
      if (wb_enable1 && wb_rd1 != '0) regs[wb_rd1] <= wb_value1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      valid0 <= 1'b0;
      valid1 <= 1'b0;
    end else if (!stall) begin
      valid0 <= dec_valid0;
      valid1 <= dec_valid1;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      pc0    <= dec_pc0;
      rd0    <= dec_rd0;
      write0 <= dec_valid0 && dec_op0 != op_none && dec_rd0 != '0;
      value0 <= alu(dec_op0, a0, b0);
      pc1    <= dec_pc1;
      rd1    <= dec_rd1;
      write1 <= dec_valid1 && dec_op1 != op_none && dec_rd1 != '0;
      value1 <= alu(dec_op1, a1, b1);
    end
  end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`default_nettype none

module decode_stage import core_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 stall,
  input  logic                 buf_valid0,
  input  logic                 buf_valid1,
  input  logic [xlen-1:0]      buf_pc0,
  input  logic [xlen-1:0]      buf_pc1,
  input  instr_t               buf_instr0,
  input  instr_t               buf_instr1,
  output logic                 valid0,
  output logic [xlen-1:0]      pc0,
  output alu_op_t              op0,
  output logic [reg_idx_w-1:0] rd0,
  output logic [reg_idx_w-1:0] rs1_0,
  output logic [reg_idx_w-1:0] rs2_0,
  output logic [xlen-1:0]      imm0,
  output logic                 uses_imm0,
  output logic                 valid1,
  output logic [xlen-1:0]      pc1,
  output alu_op_t              op1,
  output logic [reg_idx_w-1:0] rd1,
  output logic [reg_idx_w-1:0] rs1_1,
  output logic [reg_idx_w-1:0] rs2_1,
  output logic [xlen-1:0]      imm1,
  output logic                 uses_imm1
);

  function automatic alu_op_t decode_op(input instr_t instr);
    decode_op = op_none;
    if (instr.r_type.opcode == opcode_op) begin
      case ({instr.r_type.funct7, instr.r_type.funct3})
        {7'h00, 3'b000}: decode_op = op_add;
        {7'h20, 3'b000}: decode_op = op_sub;
        {7'h00, 3'b111}: decode_op = op_and;
        {7'h00, 3'b110}: decode_op = op_or;
        {7'h00, 3'b100}: decode_op = op_xor;
        {7'h00, 3'b010}: decode_op = op_slt;
        default:         decode_op = op_none;
      endcase
    end else if (instr.i_type.opcode == opcode_op_imm) begin
      case (instr.i_type.funct3)
        3'b000:  decode_op = op_addi;
        3'b111:  decode_op = op_andi;
        3'b110:  decode_op = op_ori;
        3'b100:  decode_op = op_xori;
        3'b010:  decode_op = op_slti;
        default: decode_op = op_none;
      endcase
    end
  endfunction

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      valid0 <= 1'b0;
      valid1 <= 1'b0;
    end else if (!stall) begin
      valid0 <= buf_valid0;
      valid1 <= buf_valid1;
    end
  end

  // Immediates are sign extended from the i_type view
  always_ff @(posedge clock) begin
    if (!stall) begin
      pc0       <= buf_pc0;
      op0       <= decode_op(buf_instr0);
      rd0       <= buf_instr0.r_type.rd;
      rs1_0     <= buf_instr0.r_type.rs1;
      rs2_0     <= buf_instr0.r_type.rs2;
      imm0      <= {{(xlen-12){buf_instr0.i_type.imm[11]}}, buf_instr0.i_type.imm};
      uses_imm0 <= buf_instr0.i_type.opcode == opcode_op_imm;
      pc1       <= buf_pc1;
      op1       <= decode_op(buf_instr1);
      rd1       <= buf_instr1.r_type.rd;
      rs1_1     <= buf_instr1.r_type.rs1;
      rs2_1     <= buf_instr1.r_type.rs2;
      imm1      <= {{(xlen-12){buf_instr1.i_type.imm[11]}}, buf_instr1.i_type.imm};
      uses_imm1 <= buf_instr1.i_type.opcode == opcode_op_imm;
    end
  end

endmodule

`default_nettype wire

//--- source/buffer_stage.sv
`default_nettype none

module buffer_stage import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            flush,
  input  logic            stall,
  input  logic            valid_in0,
  input  logic            valid_in1,
  input  logic [xlen-1:0] pc_in0,
  input  logic [xlen-1:0] pc_in1,
  input  instr_t          instr_in0,
  input  instr_t          instr_in1,
  output logic            valid0,
  output logic            valid1,
  output logic [xlen-1:0] pc0,
  output logic [xlen-1:0] pc1,
  output instr_t          instr0,
  output instr_t          instr1
);

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      valid0 <= 1'b0;
      valid1 <= 1'b0;
      pc0    <= reset_pc;
      pc1    <= reset_pc;
      instr0 <= '0;
      instr1 <= '0;
    end else if (!stall) begin
      valid0 <= valid_in0;
      valid1 <= valid_in1;
      pc0    <= valid_in0 ? pc_in0 : reset_pc;  // Empty lanes keep reset_pc
      pc1    <= valid_in1 ? pc_in1 : reset_pc;
      instr0 <= instr_in0;
      instr1 <= instr_in1;
    end
  end

endmodule

`default_nettype wire

//--- source/issue_queue.sv
`default_nettype none

module issue_queue import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            flush,
  input  logic            stall,
  input  logic            fetch_valid,
  input  logic [xlen-1:0] fetch_pc,
  input  instr_t          fetch_instr,
  output logic            fetch_ready,
  output logic            issue_valid0,
  output logic            issue_valid1,
  output logic [xlen-1:0] issue_pc0,
  output logic [xlen-1:0] issue_pc1,
  output instr_t          issue_instr0,
  output instr_t          issue_instr1
);

  logic [xlen-1:0] pc_mem [queue_depth];
  instr_t          instr_mem [queue_depth];

  logic [$clog2(queue_depth)-1:0] head;
  logic [$clog2(queue_depth)-1:0] tail;
  logic [$clog2(queue_depth)-1:0] head_second;
  logic [$clog2(queue_depth):0]   count;

  logic       push;
  logic       writes0;
  logic       dependent;
  logic [1:0] pop;

  assign head_second  = head + 1'b1;
  assign issue_pc0    = pc_mem[head];
  assign issue_pc1    = pc_mem[head_second];
  assign issue_instr0 = instr_mem[head];
  assign issue_instr1 = instr_mem[head_second];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pairing rule
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign writes0 = (issue_instr0.r_type.opcode == opcode_op ||
                    issue_instr0.r_type.opcode == opcode_op_imm) &&
                   issue_instr0.r_type.rd != '0;

  // rs2 only counts for the register form
  assign dependent = writes0 &&
    (issue_instr1.r_type.rs1 == issue_instr0.r_type.rd ||
     (issue_instr1.r_type.opcode == opcode_op &&
      issue_instr1.r_type.rs2 == issue_instr0.r_type.rd));

  assign issue_valid0 = count != '0;
  assign issue_valid1 = count > 1 && !dependent;

  always_comb begin
    if (stall) pop = 2'd0;
    else if (issue_valid1) pop = 2'd2;
    else if (issue_valid0) pop = 2'd1;
    else pop = 2'd0;
  end

  assign fetch_ready = count != queue_depth && !flush;
  assign push        = fetch_valid && fetch_ready;

  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[tail]    <= fetch_pc;
      instr_mem[tail] <= fetch_instr;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + pop;  // Wraps at depth
      tail  <= tail + push;
      count <= count + ($clog2(queue_depth)+1)'(push) - ($clog2(queue_depth)+1)'(pop);
    end
  end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int xlen        = 32;
  localparam int reg_count   = 32;
  localparam int reg_idx_w   = $clog2(reg_count);
  localparam int queue_depth = 4;

  localparam logic [xlen-1:0] reset_pc = '0;  // Pc of an empty lane

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  typedef enum logic [3:0] {
    op_none,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_addi,
    op_andi,
    op_ori,
    op_xori,
    op_slti
  } alu_op_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One instruction word, register or immediate form
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef union packed {
    struct packed {
      logic [6:0]           funct7;
      logic [reg_idx_w-1:0] rs2;
      logic [reg_idx_w-1:0] rs1;
      logic [2:0]           funct3;
      logic [reg_idx_w-1:0] rd;
      logic [6:0]           opcode;
    } r_type;
    struct packed {
      logic [11:0]          imm;
      logic [reg_idx_w-1:0] rs1;
      logic [2:0]           funct3;
      logic [reg_idx_w-1:0] rd;
      logic [6:0]           opcode;
    } i_type;
  } instr_t;

endpackage

`default_nettype wire
